// File: hdl/id_pkg.sv
package id_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // return address register for JAL, BLTZAL, BGEZAL
    localparam reg_addr_t LINK_REG = 5'd31;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LB      = 6'h20;
    localparam logic [5:0] OP_LH      = 6'h21;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_LBU     = 6'h24;
    localparam logic [5:0] OP_LHU     = 6'h25;
    localparam logic [5:0] OP_SB      = 6'h28;
    localparam logic [5:0] OP_SH      = 6'h29;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // SPECIAL function field
    localparam logic [5:0] FUNC_SLL  = 6'h00;
    localparam logic [5:0] FUNC_SRL  = 6'h02;
    localparam logic [5:0] FUNC_SRA  = 6'h03;
    localparam logic [5:0] FUNC_SLLV = 6'h04;
    localparam logic [5:0] FUNC_SRLV = 6'h06;
    localparam logic [5:0] FUNC_SRAV = 6'h07;
    localparam logic [5:0] FUNC_JR   = 6'h08;
    localparam logic [5:0] FUNC_JALR = 6'h09;
    localparam logic [5:0] FUNC_ADD  = 6'h20;
    localparam logic [5:0] FUNC_ADDU = 6'h21;
    localparam logic [5:0] FUNC_SUB  = 6'h22;
    localparam logic [5:0] FUNC_SUBU = 6'h23;
    localparam logic [5:0] FUNC_AND  = 6'h24;
    localparam logic [5:0] FUNC_OR   = 6'h25;
    localparam logic [5:0] FUNC_XOR  = 6'h26;
    localparam logic [5:0] FUNC_NOR  = 6'h27;
    localparam logic [5:0] FUNC_SLT  = 6'h2a;
    localparam logic [5:0] FUNC_SLTU = 6'h2b;

    // REGIMM rt selector where bit 4 marks the link forms
    localparam reg_addr_t RT_BLTZ   = 5'h00;
    localparam reg_addr_t RT_BGEZ   = 5'h01;
    localparam reg_addr_t RT_BLTZAL = 5'h10;
    localparam reg_addr_t RT_BGEZAL = 5'h11;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_MOV, ALU_BAJ,
        ALU_LW, ALU_LB, ALU_LH, ALU_LBU, ALU_LHU, ALU_SW, ALU_SB, ALU_SH
    } alu_op_t;

    typedef enum logic [1:0] {
        MEM_NONE, MEM_LOAD, MEM_STORE
    } mem_kind_t;

    typedef enum logic [3:0] {
        BR_NONE, BR_J, BR_JR, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ
    } branch_kind_t;

    typedef struct packed {
        logic         rd_en1;
        logic         rd_en2;
        reg_addr_t    rd_addr1;
        reg_addr_t    rd_addr2;
        logic         wr_en;
        reg_addr_t    wr_addr;
        alu_op_t      alu_op;
        logic         is_signed;
        word_t        imm;
        branch_kind_t branch;
        logic         invalid;
    } decode_t;

    typedef struct packed {
        logic      wr_en;
        reg_addr_t wr_addr;
        alu_op_t   alu_op;
        logic      is_signed;
        word_t     op1;
        word_t     op2;
        logic      invalid;
    } issue_t;

    localparam issue_t ISSUE_BUBBLE = '{
        wr_en: 1'b0, wr_addr: '0, alu_op: ALU_NOP, is_signed: 1'b0,
        op1: '0, op2: '0, invalid: 1'b0
    };

endpackage

// File: hdl/bypass_if.sv
`timescale 1ns/100ps

interface bypass_if;

    // instruction currently in EX
    logic        ex_wr_en;
    logic [4:0]  ex_wr_addr;
    logic [31:0] ex_wr_data;
    logic [1:0]  ex_mem_kind;

    // instruction currently in MEM
    logic        mem_wr_en;
    logic [4:0]  mem_wr_addr;
    logic [31:0] mem_wr_data;

    modport producer (
        output ex_wr_en, ex_wr_addr, ex_wr_data, ex_mem_kind,
        output mem_wr_en, mem_wr_addr, mem_wr_data
    );

    modport consumer (
        input ex_wr_en, ex_wr_addr, ex_wr_data, ex_mem_kind,
        input mem_wr_en, mem_wr_addr, mem_wr_data
    );

endinterface

// File: hdl/instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder (
    input  id_pkg::word_t   inst_i,
    output id_pkg::decode_t dec_o
);
    import id_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    reg_addr_t  shamt;
    word_t      imm_sext;
    word_t      imm_zext;

    assign opcode   = inst_i[31:26];
    assign rs       = inst_i[25:21];
    assign rt       = inst_i[20:16];
    assign rd       = inst_i[15:11];
    assign shamt    = inst_i[10:6];
    assign funct    = inst_i[5:0];
    assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};
    assign imm_zext = {16'b0, inst_i[15:0]};

    function automatic alu_op_t special_alu(input logic [5:0] f);
        case (f)
            FUNC_ADD, FUNC_ADDU:   return ALU_ADD;
            FUNC_SUB, FUNC_SUBU:   return ALU_SUB;
            FUNC_AND:              return ALU_AND;
            FUNC_OR:               return ALU_OR;
            FUNC_XOR:              return ALU_XOR;
            FUNC_NOR:              return ALU_NOR;
            FUNC_SLT, FUNC_SLTU:   return ALU_SLT;
            FUNC_SLL, FUNC_SLLV:   return ALU_SLL;
            FUNC_SRL, FUNC_SRLV:   return ALU_SRL;
            FUNC_SRA, FUNC_SRAV:   return ALU_SRA;
            default:               return ALU_NOP;
        endcase
    endfunction

    // immediate-form and memory opcodes
    function automatic alu_op_t itype_alu(input logic [5:0] op);
        case (op)
            OP_ADDI, OP_ADDIU: return ALU_ADD;
            OP_SLTI, OP_SLTIU: return ALU_SLT;
            OP_ANDI:           return ALU_AND;
            OP_ORI:            return ALU_OR;
            OP_XORI:           return ALU_XOR;
            OP_LW:             return ALU_LW;
            OP_LB:             return ALU_LB;
            OP_LH:             return ALU_LH;
            OP_LBU:            return ALU_LBU;
            OP_LHU:            return ALU_LHU;
            OP_SW:             return ALU_SW;
            OP_SB:             return ALU_SB;
            OP_SH:             return ALU_SH;
            default:           return ALU_NOP;
        endcase
    endfunction

    always_comb begin
        // anything not matched below stays invalid with all enables low
        dec_o         = '0;
        dec_o.invalid = 1'b1;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FUNC_ADD, FUNC_ADDU, FUNC_SUB, FUNC_SUBU, FUNC_AND,
                    FUNC_OR, FUNC_XOR, FUNC_NOR, FUNC_SLT, FUNC_SLTU: begin
                        if (shamt == '0) begin
                            dec_o.rd_en1    = 1'b1;
                            dec_o.rd_addr1  = rs;
                            dec_o.rd_en2    = 1'b1;
                            dec_o.rd_addr2  = rt;
                            dec_o.wr_en     = 1'b1;
                            dec_o.wr_addr   = rd;
                            dec_o.alu_op    = special_alu(funct);
                            dec_o.is_signed = funct inside {FUNC_ADD, FUNC_SUB, FUNC_SLT};
                            dec_o.invalid   = 1'b0;
                        end
                    end
                    FUNC_SLL, FUNC_SRL, FUNC_SRA: begin
                        if (rs == '0) begin
                            dec_o.rd_en1   = 1'b1;
                            dec_o.rd_addr1 = rt;
                            dec_o.imm      = {{(XLEN-REG_ADDR_W){1'b0}}, shamt};
                            dec_o.wr_en    = 1'b1;
                            dec_o.wr_addr  = rd;
                            dec_o.alu_op   = special_alu(funct);
                            dec_o.invalid  = 1'b0;
                        end
                    end
                    // variable shifts put the value in op1 and the amount in op2
                    FUNC_SLLV, FUNC_SRLV, FUNC_SRAV: begin
                        if (shamt == '0) begin
                            dec_o.rd_en1   = 1'b1;
                            dec_o.rd_addr1 = rt;
                            dec_o.rd_en2   = 1'b1;
                            dec_o.rd_addr2 = rs;
                            dec_o.wr_en    = 1'b1;
                            dec_o.wr_addr  = rd;
                            dec_o.alu_op   = special_alu(funct);
                            dec_o.invalid  = 1'b0;
                        end
                    end
                    FUNC_JR, FUNC_JALR: begin
                        if (rt == '0 && shamt == '0 && (funct == FUNC_JALR || rd == '0)) begin
                            dec_o.rd_en1   = 1'b1;
                            dec_o.rd_addr1 = rs;
                            dec_o.branch   = BR_JR;
                            dec_o.invalid  = 1'b0;
                            if (funct == FUNC_JALR) begin
                                dec_o.wr_en   = 1'b1;
                                dec_o.wr_addr = rd;
                                dec_o.alu_op  = ALU_BAJ;
                            end
                        end
                    end
                    default: ;
                endcase
            end
            OP_REGIMM: begin
                if (rt inside {RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL}) begin
                    dec_o.rd_en1   = 1'b1;
                    dec_o.rd_addr1 = rs;
                    dec_o.branch   = rt[0] ? BR_GEZ : BR_LTZ;
                    dec_o.invalid  = 1'b0;
                    if (rt[4]) begin
                        dec_o.wr_en   = 1'b1;
                        dec_o.wr_addr = LINK_REG;
                        dec_o.alu_op  = ALU_BAJ;
                    end
                end
            end
            OP_J, OP_JAL: begin
                dec_o.branch  = BR_J;
                dec_o.invalid = 1'b0;
                if (opcode == OP_JAL) begin
                    dec_o.wr_en   = 1'b1;
                    dec_o.wr_addr = LINK_REG;
                    dec_o.alu_op  = ALU_BAJ;
                end
            end
            OP_BEQ, OP_BNE: begin
                dec_o.rd_en1   = 1'b1;
                dec_o.rd_addr1 = rs;
                dec_o.rd_en2   = 1'b1;
                dec_o.rd_addr2 = rt;
                dec_o.branch   = (opcode == OP_BEQ) ? BR_EQ : BR_NE;
                dec_o.invalid  = 1'b0;
            end
            OP_BLEZ, OP_BGTZ: begin
                if (rt == '0) begin
                    dec_o.rd_en1   = 1'b1;
                    dec_o.rd_addr1 = rs;
                    dec_o.branch   = (opcode == OP_BLEZ) ? BR_LEZ : BR_GTZ;
                    dec_o.invalid  = 1'b0;
                end
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI,
            OP_LW, OP_LB, OP_LH, OP_LBU, OP_LHU: begin
                dec_o.rd_en1    = 1'b1;
                dec_o.rd_addr1  = rs;
                dec_o.wr_en     = 1'b1;
                dec_o.wr_addr   = rt;
                dec_o.imm       = (opcode inside {OP_ANDI, OP_ORI, OP_XORI}) ? imm_zext
                                                                              : imm_sext;
                dec_o.alu_op    = itype_alu(opcode);
                dec_o.is_signed = opcode inside {OP_ADDI, OP_SLTI};
                dec_o.invalid   = 1'b0;
            end
            OP_SW, OP_SB, OP_SH: begin
                dec_o.rd_en1   = 1'b1;
                dec_o.rd_addr1 = rs;
                dec_o.rd_en2   = 1'b1;
                dec_o.rd_addr2 = rt;
                dec_o.imm      = imm_sext;
                dec_o.alu_op   = itype_alu(opcode);
                dec_o.invalid  = 1'b0;
            end
            OP_LUI: begin
                if (rs == '0) begin
                    dec_o.wr_en   = 1'b1;
                    dec_o.wr_addr = rt;
                    dec_o.imm     = {inst_i[15:0], 16'b0};
                    dec_o.alu_op  = ALU_MOV;
                    dec_o.invalid = 1'b0;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/operand_bypass.sv
`timescale 1ns/100ps

module operand_bypass (
    input  logic              rd_en_i,
    input  id_pkg::reg_addr_t rd_addr_i,
    input  id_pkg::word_t     reg_data_i,
    input  id_pkg::word_t     imm_i,
    bypass_if.consumer        byp,
    output id_pkg::word_t     operand_o
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = byp.ex_wr_en && (byp.ex_wr_addr == rd_addr_i);
    assign mem_hit = byp.mem_wr_en && (byp.mem_wr_addr == rd_addr_i);

    // youngest producer wins
    always_comb begin
        if (!rd_en_i) begin
            operand_o = imm_i;
        end else if (ex_hit) begin
            operand_o = byp.ex_wr_data;
        end else if (mem_hit) begin
            operand_o = byp.mem_wr_data;
        end else begin
            operand_o = reg_data_i;
        end
    end

endmodule

// File: hdl/branch_resolver.sv
`timescale 1ns/100ps

module branch_resolver (
    input  id_pkg::word_t        pc_i,
    input  id_pkg::word_t        inst_i,
    input  id_pkg::branch_kind_t kind_i,
    input  id_pkg::word_t        op1_i,
    input  id_pkg::word_t        op2_i,
    output logic                 taken_o,
    output id_pkg::word_t        target_o
);
    import id_pkg::*;

    word_t pc_plus4;
    word_t jump_target;
    word_t rel_target;
    logic  op1_zero;

    assign pc_plus4    = pc_i + 32'd4;
    assign jump_target = {pc_plus4[31:28], inst_i[25:0], 2'b00};
    assign rel_target  = pc_plus4 + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
    assign op1_zero    = (op1_i == '0);

    always_comb begin
        case (kind_i)
            BR_J, BR_JR: taken_o = 1'b1;
            BR_EQ:       taken_o = (op1_i == op2_i);
            BR_NE:       taken_o = (op1_i != op2_i);
            BR_LEZ:      taken_o = op1_i[31] || op1_zero;
            BR_GTZ:      taken_o = !op1_i[31] && !op1_zero;
            BR_LTZ:      taken_o = op1_i[31];
            BR_GEZ:      taken_o = !op1_i[31];
            default:     taken_o = 1'b0;
        endcase
    end

    // target reads zero when nothing is taken
    always_comb begin
        if (!taken_o) begin
            target_o = '0;
        end else if (kind_i == BR_J) begin
            target_o = jump_target;
        end else if (kind_i == BR_JR) begin
            target_o = op1_i;
        end else begin
            target_o = rel_target;
        end
    end

endmodule

// File: hdl/id_issue_reg.sv
`timescale 1ns/100ps

module id_issue_reg (
    input  logic            clk,
    input  logic            rst,
    input  id_pkg::decode_t dec_i,
    input  id_pkg::word_t   op1_i,
    input  id_pkg::word_t   op2_i,
    bypass_if.consumer      byp,
    output logic            pause_o,
    output id_pkg::issue_t  issue_o
);
    import id_pkg::*;

    logic ex_load;
    logic hit1;
    logic hit2;

    // load result only exists after MEM, so a reader must wait a cycle
    assign ex_load = (byp.ex_mem_kind == MEM_LOAD);
    assign hit1    = dec_i.rd_en1 && (byp.ex_wr_addr == dec_i.rd_addr1);
    assign hit2    = dec_i.rd_en2 && (byp.ex_wr_addr == dec_i.rd_addr2);
    assign pause_o = ex_load && (hit1 || hit2);

    always_ff @(posedge clk) begin
        if (rst || pause_o) begin
            issue_o <= ISSUE_BUBBLE;
        end else begin
            issue_o.wr_en     <= dec_i.wr_en;
            issue_o.wr_addr   <= dec_i.wr_addr;
            issue_o.alu_op    <= dec_i.alu_op;
            issue_o.is_signed <= dec_i.is_signed;
            issue_o.op1       <= op1_i;
            issue_o.op2       <= op2_i;
            issue_o.invalid   <= dec_i.invalid;
        end
    end

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic              clk,
    input  logic              rst,
    input  id_pkg::word_t     inst_i,
    input  id_pkg::word_t     pc_i,
    input  id_pkg::word_t     reg_data1_i,
    input  id_pkg::word_t     reg_data2_i,
    input  logic              ex_wr_en_i,
    input  id_pkg::reg_addr_t ex_wr_addr_i,
    input  id_pkg::word_t     ex_wr_data_i,
    input  id_pkg::mem_kind_t ex_mem_kind_i,
    input  logic              mem_wr_en_i,
    input  id_pkg::reg_addr_t mem_wr_addr_i,
    input  id_pkg::word_t     mem_wr_data_i,
    output id_pkg::reg_addr_t rd_addr1_o,
    output id_pkg::reg_addr_t rd_addr2_o,
    output logic              rd_en1_o,
    output logic              rd_en2_o,
    output logic              pause_request_o,
    output logic              branch_taken_o,
    output id_pkg::word_t     branch_target_o,
    output logic              wr_en_o,
    output id_pkg::reg_addr_t wr_addr_o,
    output id_pkg::alu_op_t   alu_op_o,
    output logic              signed_o,
    output id_pkg::word_t     op1_o,
    output id_pkg::word_t     op2_o,
    output logic              invalid_o
);
    import id_pkg::*;

    decode_t dec;
    word_t   link_addr;
    word_t   imm_sel;
    word_t   opnd1;
    word_t   opnd2;
    word_t   issue_op1;
    issue_t  issue;
    logic    is_link;

    bypass_if byp ();

    assign byp.ex_wr_en    = ex_wr_en_i;
    assign byp.ex_wr_addr  = ex_wr_addr_i;
    assign byp.ex_wr_data  = ex_wr_data_i;
    assign byp.ex_mem_kind = ex_mem_kind_i;
    assign byp.mem_wr_en   = mem_wr_en_i;
    assign byp.mem_wr_addr = mem_wr_addr_i;
    assign byp.mem_wr_data = mem_wr_data_i;

    instr_decoder u_decoder (
        .inst_i (inst_i),
        .dec_o  (dec)
    );

    // return address rides in the immediate slot
    assign link_addr = pc_i + 32'd8;
    assign is_link   = (dec.alu_op == ALU_BAJ);
    assign imm_sel   = is_link ? link_addr : dec.imm;

    operand_bypass u_opnd1 (
        .rd_en_i    (dec.rd_en1),
        .rd_addr_i  (dec.rd_addr1),
        .reg_data_i (reg_data1_i),
        .imm_i      (imm_sel),
        .byp        (byp),
        .operand_o  (opnd1)
    );

    operand_bypass u_opnd2 (
        .rd_en_i    (dec.rd_en2),
        .rd_addr_i  (dec.rd_addr2),
        .reg_data_i (reg_data2_i),
        .imm_i      (imm_sel),
        .byp        (byp),
        .operand_o  (opnd2)
    );

    // branch compare still sees rs, EX gets the return address
    assign issue_op1 = is_link ? imm_sel : opnd1;

    branch_resolver u_branch (
        .pc_i     (pc_i),
        .inst_i   (inst_i),
        .kind_i   (dec.branch),
        .op1_i    (opnd1),
        .op2_i    (opnd2),
        .taken_o  (branch_taken_o),
        .target_o (branch_target_o)
    );

    id_issue_reg u_issue (
        .clk     (clk),
        .rst     (rst),
        .dec_i   (dec),
        .op1_i   (issue_op1),
        .op2_i   (opnd2),
        .byp     (byp),
        .pause_o (pause_request_o),
        .issue_o (issue)
    );

    assign rd_addr1_o = dec.rd_addr1;
    assign rd_addr2_o = dec.rd_addr2;
    assign rd_en1_o   = dec.rd_en1;
    assign rd_en2_o   = dec.rd_en2;

    assign wr_en_o   = issue.wr_en;
    assign wr_addr_o = issue.wr_addr;
    assign alu_op_o  = issue.alu_op;
    assign signed_o  = issue.is_signed;
    assign op1_o     = issue.op1;
    assign op2_o     = issue.op2;
    assign invalid_o = issue.invalid;

endmodule

// File: tests/decode_checker.sv
`timescale 1ns/100ps

module decode_checker (
    input  logic              clk,
    input  logic              rst,
    input  logic              vec_valid_i,
    input  int                vec_idx_i,
    input  logic [31:0]       group_i,
    input  logic [13:0][31:0] exp_i,
    input  logic              rd_en1_i,
    input  logic              rd_en2_i,
    input  logic [4:0]        rd_addr1_i,
    input  logic [4:0]        rd_addr2_i,
    input  logic              pause_i,
    input  logic              taken_i,
    input  logic [31:0]       target_i,
    input  logic              wr_en_i,
    input  logic [4:0]        wr_addr_i,
    input  logic [4:0]        alu_op_i,
    input  logic              signed_i,
    input  logic [31:0]       op1_i,
    input  logic [31:0]       op2_i,
    input  logic              invalid_i,
    output int                error_count_o
);

    logic [13:0][31:0] prev_exp;
    logic              prev_valid = 1'b0;
    logic              seen_edge = 1'b0;
    int                prev_idx;
    logic [31:0]       prev_group;
    int                err_count = 0;

    assign error_count_o = err_count;

    function automatic string group_name(input logic [31:0] g);
        case (g)
            32'd0:   return "reset";
            32'd1:   return "alu";
            32'd2:   return "forward";
            32'd3:   return "pause";
            32'd4:   return "branch";
            32'd5:   return "invalid";
            default: return "unknown";
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            err_count++;
        end
    endtask

    // same-cycle outputs against the current line
    task automatic check_comb();
        string tag;
        tag = $sformatf("%s#%0d", group_name(group_i), vec_idx_i);
        compare({tag, " rd_en1"}, exp_i[0], {31'b0, rd_en1_i});
        compare({tag, " rd_en2"}, exp_i[1], {31'b0, rd_en2_i});
        compare({tag, " rd_addr1"}, exp_i[2], {27'b0, rd_addr1_i});
        compare({tag, " rd_addr2"}, exp_i[3], {27'b0, rd_addr2_i});
        compare({tag, " pause"}, exp_i[4], {31'b0, pause_i});
        compare({tag, " taken"}, exp_i[5], {31'b0, taken_i});
        compare({tag, " target"}, exp_i[6], target_i);
    endtask

    // registered outputs against the line before
    task automatic check_issue();
        string tag;
        tag = $sformatf("%s#%0d", group_name(prev_group), prev_idx);
        compare({tag, " wr_en"}, prev_exp[7], {31'b0, wr_en_i});
        compare({tag, " wr_addr"}, prev_exp[8], {27'b0, wr_addr_i});
        compare({tag, " alu_op"}, prev_exp[9], {27'b0, alu_op_i});
        compare({tag, " signed"}, prev_exp[10], {31'b0, signed_i});
        compare({tag, " op1"}, prev_exp[11], op1_i);
        compare({tag, " op2"}, prev_exp[12], op2_i);
        compare({tag, " invalid"}, prev_exp[13], {31'b0, invalid_i});
    endtask

    always @(posedge clk) begin
        seen_edge <= 1'b1;
        if (rst) begin
            // bubble is all zero
            prev_valid <= 1'b1;
            prev_exp   <= '0;
            prev_idx   <= -1;
            prev_group <= '0;
        end else begin
            prev_valid <= vec_valid_i;
            prev_exp   <= exp_i;
            prev_idx   <= vec_idx_i;
            prev_group <= group_i;
        end
    end

    always @(negedge clk) begin
        if (vec_valid_i && !rst) begin
            check_comb();
        end
        if (seen_edge && prev_valid) begin
            check_issue();
        end
    end

endmodule

// File: tests/tb_decode_stage.sv
`timescale 1ns/100ps

module tb_decode_stage;
    import id_pkg::*;

    localparam int NUM_VEC     = 34;
    localparam int NUM_FIELD   = 26;
    localparam int RESET_CYC   = 16;
    localparam int CYCLE_LIMIT = RESET_CYC + NUM_VEC + 20;

    logic      clk;
    logic      rst;
    word_t     inst;
    word_t     pc;
    word_t     reg_data1;
    word_t     reg_data2;
    logic      ex_wr_en;
    reg_addr_t ex_wr_addr;
    word_t     ex_wr_data;
    mem_kind_t ex_mem_kind;
    logic      mem_wr_en;
    reg_addr_t mem_wr_addr;
    word_t     mem_wr_data;

    reg_addr_t rd_addr1;
    reg_addr_t rd_addr2;
    logic      rd_en1;
    logic      rd_en2;
    logic      pause_request;
    logic      branch_taken;
    word_t     branch_target;
    logic      wr_en;
    reg_addr_t wr_addr;
    alu_op_t   alu_op;
    logic      is_signed;
    word_t     op1;
    word_t     op2;
    logic      invalid;

    logic [31:0]       vec_mem [0:NUM_VEC*NUM_FIELD-1];
    logic [13:0][31:0] exp_fields;
    logic [31:0]       vec_group;
    logic              vec_valid;
    int                vec_idx;
    int                error_count;
    int                cycle_count = 0;

    decode_stage dut0 (
        .clk             (clk),
        .rst             (rst),
        .inst_i          (inst),
        .pc_i            (pc),
        .reg_data1_i     (reg_data1),
        .reg_data2_i     (reg_data2),
        .ex_wr_en_i      (ex_wr_en),
        .ex_wr_addr_i    (ex_wr_addr),
        .ex_wr_data_i    (ex_wr_data),
        .ex_mem_kind_i   (ex_mem_kind),
        .mem_wr_en_i     (mem_wr_en),
        .mem_wr_addr_i   (mem_wr_addr),
        .mem_wr_data_i   (mem_wr_data),
        .rd_addr1_o      (rd_addr1),
        .rd_addr2_o      (rd_addr2),
        .rd_en1_o        (rd_en1),
        .rd_en2_o        (rd_en2),
        .pause_request_o (pause_request),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .wr_en_o         (wr_en),
        .wr_addr_o       (wr_addr),
        .alu_op_o        (alu_op),
        .signed_o        (is_signed),
        .op1_o           (op1),
        .op2_o           (op2),
        .invalid_o       (invalid)
    );

    decode_checker checker0 (
        .clk           (clk),
        .rst           (rst),
        .vec_valid_i   (vec_valid),
        .vec_idx_i     (vec_idx),
        .group_i       (vec_group),
        .exp_i         (exp_fields),
        .rd_en1_i      (rd_en1),
        .rd_en2_i      (rd_en2),
        .rd_addr1_i    (rd_addr1),
        .rd_addr2_i    (rd_addr2),
        .pause_i       (pause_request),
        .taken_i       (branch_taken),
        .target_i      (branch_target),
        .wr_en_i       (wr_en),
        .wr_addr_i     (wr_addr),
        .alu_op_i      (alu_op),
        .signed_i      (is_signed),
        .op1_i         (op1),
        .op2_i         (op2),
        .invalid_i     (invalid),
        .error_count_o (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one vector line holds the group, 11 stimulus fields and 14 expected fields
    task automatic apply_vector(input int v);
        int base;
        base = v * NUM_FIELD;
        vec_group   <= vec_mem[base];
        inst        <= vec_mem[base+1];
        pc          <= vec_mem[base+2];
        reg_data1   <= vec_mem[base+3];
        reg_data2   <= vec_mem[base+4];
        ex_wr_en    <= vec_mem[base+5][0];
        ex_wr_addr  <= vec_mem[base+6][4:0];
        ex_wr_data  <= vec_mem[base+7];
        ex_mem_kind <= mem_kind_t'(vec_mem[base+8][1:0]);
        mem_wr_en   <= vec_mem[base+9][0];
        mem_wr_addr <= vec_mem[base+10][4:0];
        mem_wr_data <= vec_mem[base+11];
        for (int i = 0; i < 14; i++) begin
            exp_fields[i] <= vec_mem[base+12+i];
        end
        vec_idx   <= v;
        vec_valid <= 1'b1;
    endtask

    initial begin
        rst         <= 1'b1;
        inst        <= '0;
        pc          <= '0;
        reg_data1   <= '0;
        reg_data2   <= '0;
        ex_wr_en    <= 1'b0;
        ex_wr_addr  <= '0;
        ex_wr_data  <= '0;
        ex_mem_kind <= MEM_NONE;
        mem_wr_en   <= 1'b0;
        mem_wr_addr <= '0;
        mem_wr_data <= '0;
        exp_fields  <= '0;
        vec_group   <= '0;
        vec_idx     <= 0;
        vec_valid   <= 1'b0;
        $readmemh("tests/decode_vectors.txt", vec_mem);
        if ($isunknown(vec_mem[NUM_VEC*NUM_FIELD-1])) begin
            $display("vector file is missing or shorter than expected");
            $display("Done: errors found");
            $finish;
        end else begin
            repeat (RESET_CYC) @(posedge clk);
            rst <= 1'b0;
            for (int v = 0; v < NUM_VEC; v++) begin
                apply_vector(v);
                @(posedge clk);
            end
            vec_valid <= 1'b0;
            // last issue lands one edge later
            @(posedge clk);
            @(negedge clk);
            $display("errors: %0d over %0d vectors", error_count, NUM_VEC);
            if (error_count == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

endmodule

// File: tests/decode_vectors.txt
// grp inst pc rd1 rd2 ex_en ex_addr ex_data ex_kind mem_en mem_addr mem_data
// then ren1 ren2 raddr1 raddr2 pause taken target wr_en wr_addr alu signed op1 op2 invalid
1 00221820 1000 11111111 22222222 0 0 0 0 0 0 0 1 1 1 2 0 0 0 1 3 1 1 11111111 22222222 0
1 00a62023 1000 11111111 22222222 0 0 0 0 0 0 0 1 1 5 6 0 0 0 1 4 2 0 11111111 22222222 0
1 2027fffc 1000 11111111 22222222 0 0 0 0 0 0 0 1 0 1 0 0 0 0 1 7 1 1 11111111 fffffffc 0
1 34488001 1000 11111111 22222222 0 0 0 0 0 0 0 1 0 2 0 0 0 0 1 8 4 0 11111111 00008001 0
1 2c298000 1000 11111111 22222222 0 0 0 0 0 0 0 1 0 1 0 0 0 0 1 9 7 0 11111111 ffff8000 0
1 3c0a1234 1000 11111111 22222222 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 a b 0 12340000 12340000 0
1 000c5940 1000 11111111 22222222 0 0 0 0 0 0 0 1 0 c 0 0 0 0 1 b 8 0 11111111 00000005 0
1 01ee6804 1000 11111111 22222222 0 0 0 0 0 0 0 1 1 e f 0 0 0 1 d 8 0 11111111 22222222 0
1 00020fc3 1000 11111111 22222222 0 0 0 0 0 0 0 1 0 2 0 0 0 0 1 1 a 0 11111111 0000001f 0
2 00221820 1000 11111111 22222222 1 1 aaaa0001 0 1 1 bbbb0001 1 1 1 2 0 0 0 1 3 1 1 aaaa0001 22222222 0
2 00221820 1000 11111111 22222222 1 5 aaaa0002 0 1 2 bbbb0002 1 1 1 2 0 0 0 1 3 1 1 11111111 bbbb0002 0
2 00221820 1000 11111111 22222222 1 2 aaaa0003 0 1 2 bbbb0003 1 1 1 2 0 0 0 1 3 1 1 11111111 aaaa0003 0
2 00221820 1000 11111111 22222222 0 1 aaaa0004 0 0 1 bbbb0004 1 1 1 2 0 0 0 1 3 1 1 11111111 22222222 0
2 00221820 1000 11111111 22222222 1 2 aaaa0005 0 1 1 bbbb0005 1 1 1 2 0 0 0 1 3 1 1 bbbb0005 aaaa0005 0
3 00221820 1000 11111111 22222222 1 2 cccc0001 1 0 0 0 1 1 1 2 1 0 0 0 0 0 0 0 0 0
3 00221820 1000 11111111 22222222 0 0 0 0 1 2 dddd0001 1 1 1 2 0 0 0 1 3 1 1 11111111 dddd0001 0
3 00221820 1000 11111111 22222222 0 2 cccc0003 2 0 0 0 1 1 1 2 0 0 0 1 3 1 1 11111111 22222222 0
3 00221820 1000 11111111 22222222 1 7 cccc0004 1 0 0 0 1 1 1 2 0 0 0 1 3 1 1 11111111 22222222 0
3 2027fffc 1000 11111111 22222222 1 0 cccc0005 1 0 0 0 1 0 1 0 0 0 0 1 7 1 1 11111111 fffffffc 0
4 10220003 1000 5 5 0 0 0 0 0 0 0 1 1 1 2 0 1 1010 0 0 0 0 5 5 0
4 14220003 1000 5 5 0 0 0 0 0 0 0 1 1 1 2 0 0 0 0 0 0 0 5 5 0
4 1820fffe 1000 0 22222222 0 0 0 0 0 0 0 1 0 1 0 0 1 ffc 0 0 0 0 0 0 0
4 1c200001 1000 80000000 22222222 0 0 0 0 0 0 0 1 0 1 0 0 0 0 0 0 0 0 80000000 0 0
4 04310004 1000 1 22222222 0 0 0 0 0 0 0 1 0 1 0 0 1 1014 1 1f c 0 1008 1008 0
4 04200004 1000 1 22222222 0 0 0 0 0 0 0 1 0 1 0 0 0 0 0 0 0 0 1 0 0
4 08000100 f0001000 11111111 22222222 0 0 0 0 0 0 0 0 0 0 0 0 1 f0000400 0 0 0 0 0 0 0
4 0c000200 1000 11111111 22222222 0 0 0 0 0 0 0 0 0 0 0 0 1 800 1 1f c 0 1008 1008 0
4 00a00008 1000 2000 22222222 0 0 0 0 0 0 0 1 0 5 0 0 1 2000 0 0 0 0 2000 0 0
4 00c0f809 1000 3000 22222222 1 6 4000 0 0 0 0 1 0 6 0 0 1 4000 1 1f c 0 1008 1008 0
5 00220018 1000 11111111 22222222 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1
5 0000000c 1000 11111111 22222222 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1
5 42000018 1000 11111111 22222222 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1
5 fc000000 1000 11111111 22222222 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1
5 00221860 1000 11111111 22222222 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1

// File: compile.f
hdl/id_pkg.sv
hdl/bypass_if.sv
hdl/instr_decoder.sv
hdl/operand_bypass.sv
hdl/branch_resolver.sv
hdl/id_issue_reg.sv
hdl/decode_stage.sv
tests/decode_checker.sv
tests/tb_decode_stage.sv

// File: run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_decode_stage -f compile.f -o sim_decode; then
    echo "verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/sim_decode); then
    echo "$output"
    echo "simulation exited with an error status"
    exit 1
fi

echo "$output"

if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
else
    exit 1
fi
